//--- design/ex_pkg.sv
// Execute stage package with widths, operation codes and the branch-type helper

package ex_pkg;

    // Default datapath width, the stage also builds at 64
    localparam int unsigned XLEN_DEFAULT = 32;

    // Scoreboard entry ID width
    localparam int unsigned TRANS_ID_BITS = 3;

    // CSR address field of the immediate
    localparam int unsigned CSR_ADDR_BITS = 12;

    // ------------------------------------------------------------------------
    // Operation codes of the fixed latency units
    // ------------------------------------------------------------------------
    typedef enum logic [4:0] {
        // ALU
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SLT,
        OP_SLTU,
        // Branch unit
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGEU,
        OP_JALR,
        // CSR buffer
        OP_CSRRW,
        // Multiplier
        OP_MUL,
        OP_MULH
    } fu_op_e;

    // High for the four conditional branches, JALR is not one of them
    function automatic logic is_cond_branch(input fu_op_e op);
        return op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGEU};
    endfunction

endpackage

//--- design/fu_data_if.sv
// Interface carrying the isolated operands of one functional unit

`timescale 1ns/1ns

interface fu_data_if #(
    parameter int unsigned Xlen = ex_pkg::XLEN_DEFAULT
);
    import ex_pkg::*;

    fu_op_e                   operation;
    logic [Xlen-1:0]          operand_a;
    logic [Xlen-1:0]          operand_b;
    logic [Xlen-1:0]          imm;
    logic [TRANS_ID_BITS-1:0] trans_id;

    // Driven by the issue stage
    modport issue (output operation, operand_a, operand_b, imm, trans_id);

    // Seen by the execute units
    modport unit (input operation, operand_a, operand_b, imm, trans_id);

endinterface

//--- design/fu_issue.sv
// Operand isolation stage driving one operand interface per functional unit

`timescale 1ns/1ns

module fu_issue #(
    parameter int unsigned Xlen = ex_pkg::XLEN_DEFAULT
) (
    input  ex_pkg::fu_op_e                   fu_op_i,
    input  logic [Xlen-1:0]                  operand_a_i,
    input  logic [Xlen-1:0]                  operand_b_i,
    input  logic [Xlen-1:0]                  imm_i,
    input  logic [ex_pkg::TRANS_ID_BITS-1:0] trans_id_i,
    input  logic                             alu_valid_i,
    input  logic                             branch_valid_i,
    input  logic                             csr_valid_i,
    input  logic                             mult_valid_i,
    fu_data_if.issue                         alu_o,
    fu_data_if.issue                         csr_o,
    fu_data_if.issue                         mult_o
);
    import ex_pkg::*;

    // ALU and branch unit share one operand set
    logic alu_sel;

    assign alu_sel = alu_valid_i | branch_valid_i;

    // Idle units see zeros so their logic does not toggle
    assign alu_o.operation  = alu_sel ? fu_op_i : fu_op_e'('0);
    assign alu_o.operand_a  = alu_sel ? operand_a_i : '0;
    assign alu_o.operand_b  = alu_sel ? operand_b_i : '0;
    assign alu_o.imm        = alu_sel ? imm_i : '0;
    assign alu_o.trans_id   = alu_sel ? trans_id_i : '0;

    assign csr_o.operation  = csr_valid_i ? fu_op_i : fu_op_e'('0);
    assign csr_o.operand_a  = csr_valid_i ? operand_a_i : '0;
    assign csr_o.operand_b  = csr_valid_i ? operand_b_i : '0;
    assign csr_o.imm        = csr_valid_i ? imm_i : '0;
    assign csr_o.trans_id   = csr_valid_i ? trans_id_i : '0;

    assign mult_o.operation = mult_valid_i ? fu_op_i : fu_op_e'('0);
    assign mult_o.operand_a = mult_valid_i ? operand_a_i : '0;
    assign mult_o.operand_b = mult_valid_i ? operand_b_i : '0;
    assign mult_o.imm       = mult_valid_i ? imm_i : '0;
    assign mult_o.trans_id  = mult_valid_i ? trans_id_i : '0;

endmodule

//--- design/alu.sv
// Single-cycle integer ALU with the branch comparison flag

`timescale 1ns/1ns

module alu #(
    parameter int unsigned Xlen = ex_pkg::XLEN_DEFAULT
) (
    fu_data_if.unit           fu_i,
    output logic [Xlen-1:0]   result_o,
    output logic              branch_res_o
);
    import ex_pkg::*;

    localparam int unsigned ShamtBits = $clog2(Xlen);

    logic [ShamtBits-1:0] shamt;
    logic                 equal;
    logic                 signed_lt;
    logic                 unsigned_lt;
    logic                 cmp;

    assign shamt       = fu_i.operand_b[ShamtBits-1:0];
    assign equal       = fu_i.operand_a == fu_i.operand_b;
    assign signed_lt   = $signed(fu_i.operand_a) < $signed(fu_i.operand_b);
    assign unsigned_lt = fu_i.operand_a < fu_i.operand_b;

    // ------------------------------------------------------------------------
    // Result
    // ------------------------------------------------------------------------
    always_comb begin
        case (fu_i.operation)
            OP_ADD:  result_o = fu_i.operand_a + fu_i.operand_b;
            OP_SUB:  result_o = fu_i.operand_a - fu_i.operand_b;
            OP_AND:  result_o = fu_i.operand_a & fu_i.operand_b;
            OP_OR:   result_o = fu_i.operand_a | fu_i.operand_b;
            OP_XOR:  result_o = fu_i.operand_a ^ fu_i.operand_b;
            OP_SLL:  result_o = fu_i.operand_a << shamt;
            OP_SRL:  result_o = fu_i.operand_a >> shamt;
            OP_SLT:  result_o = {{(Xlen-1){1'b0}}, signed_lt};
            OP_SLTU: result_o = {{(Xlen-1){1'b0}}, unsigned_lt};
            default: result_o = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Branch comparison
    // ------------------------------------------------------------------------
    always_comb begin
        case (fu_i.operation)
            OP_BEQ:  cmp = equal;
            OP_BNE:  cmp = ~equal;
            OP_BLT:  cmp = signed_lt;
            default: cmp = ~unsigned_lt;
        endcase
        // Flag stays low for anything but a conditional branch
        branch_res_o = is_cond_branch(fu_i.operation) ? cmp : 1'b0;
    end

endmodule

//--- design/branch_unit.sv
// Branch unit with target, link address, misprediction and misalignment

`timescale 1ns/1ns

module branch_unit #(
    parameter int unsigned Xlen = ex_pkg::XLEN_DEFAULT
) (
    fu_data_if.unit           fu_i,
    input  logic [Xlen-1:0]   pc_i,
    input  logic              is_compressed_i,
    input  logic              branch_valid_i,
    input  logic              fu_valid_i,
    input  logic              branch_comp_res_i,
    input  logic              bp_taken_i,
    input  logic [Xlen-1:0]   bp_target_i,
    output logic [Xlen-1:0]   link_o,
    output logic              resolve_o,
    output logic              taken_o,
    output logic              mispredict_o,
    output logic [Xlen-1:0]   target_o,
    output logic              exception_o
);
    import ex_pkg::*;

    logic            is_jalr;
    logic [Xlen-1:0] jump_base;
    logic [Xlen-1:0] jump_sum;
    logic [Xlen-1:0] jump_target;

    // JALR is relative to rs1, conditional branches to the PC
    assign is_jalr     = fu_i.operation == OP_JALR;
    assign jump_base   = is_jalr ? fu_i.operand_a : pc_i;
    assign jump_sum    = jump_base + fu_i.imm;
    assign jump_target = {jump_sum[Xlen-1:1], jump_sum[0] & ~is_jalr};

    assign link_o = pc_i + (is_compressed_i ? Xlen'(2) : Xlen'(4));

    always_comb begin
        taken_o = branch_valid_i
                  & (is_jalr | (is_cond_branch(fu_i.operation) & branch_comp_res_i));
        target_o = taken_o ? jump_target : link_o;
        resolve_o = 1'b0;
        mispredict_o = 1'b0;
        if (branch_valid_i) begin
            resolve_o = 1'b1;
            mispredict_o = (taken_o != bp_taken_i)
                           | (taken_o & (jump_target != bp_target_i));
        end else if (fu_valid_i && bp_taken_i) begin
            // Predicted taken on a non-branch, fall through to the next PC
            resolve_o = 1'b1;
            mispredict_o = 1'b1;
        end
    end

    assign exception_o = taken_o & jump_target[0];

endmodule

//--- design/csr_buffer.sv
// One-entry CSR address buffer with ready, commit and flush

`timescale 1ns/1ns

module csr_buffer #(
    parameter int unsigned Xlen = ex_pkg::XLEN_DEFAULT
) (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             flush_i,
    fu_data_if.unit                          fu_i,
    input  logic                             csr_valid_i,
    input  logic                             csr_commit_i,
    output logic                             ready_o,
    output logic [Xlen-1:0]                  result_o,
    output logic [ex_pkg::CSR_ADDR_BITS-1:0] csr_addr_o
);
    import ex_pkg::*;

    logic                     full_q;
    logic [CSR_ADDR_BITS-1:0] addr_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
            addr_q <= '0;
        end else begin
            if (csr_valid_i) begin
                full_q <= 1'b1;
                addr_q <= fu_i.imm[CSR_ADDR_BITS-1:0];
            end
            // Retiring or squashing the instruction frees the entry
            if (csr_commit_i || flush_i) begin
                full_q <= 1'b0;
            end
        end
    end

    // Blocks further issue until the entry is freed
    assign ready_o    = ~full_q;
    assign result_o   = fu_i.operand_a;
    assign csr_addr_o = addr_q;

endmodule

//--- design/mult_unit.sv
// One-cycle registered multiplier with transaction ID and flush

`timescale 1ns/1ns

module mult_unit #(
    parameter int unsigned Xlen = ex_pkg::XLEN_DEFAULT
) (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             flush_i,
    fu_data_if.unit                          fu_i,
    input  logic                             mult_valid_i,
    output logic                             valid_o,
    output logic [Xlen-1:0]                  result_o,
    output logic [ex_pkg::TRANS_ID_BITS-1:0] trans_id_o
);
    import ex_pkg::*;

    logic signed [2*Xlen-1:0] product;
    logic [Xlen-1:0]          result_d;
    logic                     valid_q;
    logic [Xlen-1:0]          result_q;
    logic [TRANS_ID_BITS-1:0] trans_id_q;

    // Signed by signed, MULH takes the upper half
    assign product  = $signed(fu_i.operand_a) * $signed(fu_i.operand_b);
    assign result_d = (fu_i.operation == OP_MULH) ? product[2*Xlen-1:Xlen]
                                                  : product[Xlen-1:0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mult_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mult_valid_i) begin
            result_q   <= result_d;
            trans_id_q <= fu_i.trans_id;
        end
    end

    // A flush in the writeback cycle also kills the result
    assign valid_o    = valid_q & ~flush_i;
    assign result_o   = result_q;
    assign trans_id_o = trans_id_q;

endmodule

//--- design/flu_writeback.sv
// Priority result mux, valid and ready for the shared write port

`timescale 1ns/1ns

module flu_writeback #(
    parameter int unsigned Xlen = ex_pkg::XLEN_DEFAULT
) (
    input  logic                             alu_valid_i,
    input  logic                             branch_valid_i,
    input  logic                             csr_valid_i,
    input  logic [ex_pkg::TRANS_ID_BITS-1:0] issue_trans_id_i,
    input  logic [Xlen-1:0]                  alu_result_i,
    input  logic [Xlen-1:0]                  csr_result_i,
    input  logic [Xlen-1:0]                  link_i,
    input  logic                             mult_valid_i,
    input  logic [Xlen-1:0]                  mult_result_i,
    input  logic [ex_pkg::TRANS_ID_BITS-1:0] mult_trans_id_i,
    input  logic                             csr_ready_i,
    output logic [Xlen-1:0]                  result_o,
    output logic [ex_pkg::TRANS_ID_BITS-1:0] trans_id_o,
    output logic                             valid_o,
    output logic                             ready_o
);

    always_comb begin
        // Link address of a branch or jump unless a unit claims the port
        result_o   = link_i;
        trans_id_o = issue_trans_id_i;
        if (alu_valid_i) begin
            result_o = alu_result_i;
        end else if (csr_valid_i) begin
            result_o = csr_result_i;
        end else if (mult_valid_i) begin
            result_o   = mult_result_i;
            trans_id_o = mult_trans_id_i;
        end
    end

    assign valid_o = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid_i;

    // Multiplier never stalls, so only the CSR entry back-pressures
    assign ready_o = csr_ready_i;

endmodule

//--- design/ex_stage.sv
// Execute stage top level with issue, fixed latency units and writeback

`timescale 1ns/1ns

module ex_stage #(
    parameter int unsigned Xlen = ex_pkg::XLEN_DEFAULT
) (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             flush_i,
    input  ex_pkg::fu_op_e                   fu_op_i,
    input  logic [Xlen-1:0]                  operand_a_i,
    input  logic [Xlen-1:0]                  operand_b_i,
    input  logic [Xlen-1:0]                  imm_i,
    input  logic [Xlen-1:0]                  pc_i,
    input  logic [ex_pkg::TRANS_ID_BITS-1:0] trans_id_i,
    input  logic                             is_compressed_i,
    input  logic                             alu_valid_i,
    input  logic                             branch_valid_i,
    input  logic                             csr_valid_i,
    input  logic                             mult_valid_i,
    input  logic                             bp_taken_i,
    input  logic [Xlen-1:0]                  bp_target_i,
    input  logic                             csr_commit_i,
    output logic [Xlen-1:0]                  flu_result_o,
    output logic [ex_pkg::TRANS_ID_BITS-1:0] flu_trans_id_o,
    output logic                             flu_valid_o,
    output logic                             flu_ready_o,
    output logic                             flu_exception_o,
    output logic                             resolve_branch_o,
    output logic                             resolved_taken_o,
    output logic                             resolved_mispredict_o,
    output logic [Xlen-1:0]                  resolved_target_o,
    output logic [ex_pkg::CSR_ADDR_BITS-1:0] csr_addr_o
);
    import ex_pkg::*;

    logic                     alu_branch_res;
    logic [Xlen-1:0]          alu_result;
    logic [Xlen-1:0]          csr_result;
    logic [Xlen-1:0]          mult_result;
    logic [Xlen-1:0]          link_addr;
    logic                     csr_ready;
    logic                     mult_valid;
    logic [TRANS_ID_BITS-1:0] mult_trans_id;

    fu_data_if #(.Xlen(Xlen)) alu_if ();
    fu_data_if #(.Xlen(Xlen)) csr_if ();
    fu_data_if #(.Xlen(Xlen)) mult_if ();

    // ------------------------------------------------------------------------
    // Issue
    // ------------------------------------------------------------------------
    fu_issue #(.Xlen(Xlen)) fu_issue_i (
        .fu_op_i,
        .operand_a_i,
        .operand_b_i,
        .imm_i,
        .trans_id_i,
        .alu_valid_i,
        .branch_valid_i,
        .csr_valid_i,
        .mult_valid_i,
        .alu_o  (alu_if),
        .csr_o  (csr_if),
        .mult_o (mult_if)
    );

    // ------------------------------------------------------------------------
    // Execute units
    // ------------------------------------------------------------------------
    alu #(.Xlen(Xlen)) alu_i (
        .fu_i         (alu_if),
        .result_o     (alu_result),
        .branch_res_o (alu_branch_res)
    );

    // Any other unit valid lets a wrong taken prediction be caught
    branch_unit #(.Xlen(Xlen)) branch_unit_i (
        .fu_i              (alu_if),
        .pc_i,
        .is_compressed_i,
        .branch_valid_i,
        .fu_valid_i        (alu_valid_i | csr_valid_i | mult_valid_i),
        .branch_comp_res_i (alu_branch_res),
        .bp_taken_i,
        .bp_target_i,
        .link_o            (link_addr),
        .resolve_o         (resolve_branch_o),
        .taken_o           (resolved_taken_o),
        .mispredict_o      (resolved_mispredict_o),
        .target_o          (resolved_target_o),
        .exception_o       (flu_exception_o)
    );

    csr_buffer #(.Xlen(Xlen)) csr_buffer_i (
        .clk_i,
        .rst_ni,
        .flush_i,
        .fu_i         (csr_if),
        .csr_valid_i,
        .csr_commit_i,
        .ready_o      (csr_ready),
        .result_o     (csr_result),
        .csr_addr_o
    );

    mult_unit #(.Xlen(Xlen)) mult_unit_i (
        .clk_i,
        .rst_ni,
        .flush_i,
        .fu_i         (mult_if),
        .mult_valid_i,
        .valid_o      (mult_valid),
        .result_o     (mult_result),
        .trans_id_o   (mult_trans_id)
    );

    // ------------------------------------------------------------------------
    // Writeback
    // ------------------------------------------------------------------------
    flu_writeback #(.Xlen(Xlen)) flu_writeback_i (
        .alu_valid_i,
        .branch_valid_i,
        .csr_valid_i,
        .issue_trans_id_i (trans_id_i),
        .alu_result_i     (alu_result),
        .csr_result_i     (csr_result),
        .link_i           (link_addr),
        .mult_valid_i     (mult_valid),
        .mult_result_i    (mult_result),
        .mult_trans_id_i  (mult_trans_id),
        .csr_ready_i      (csr_ready),
        .result_o         (flu_result_o),
        .trans_id_o       (flu_trans_id_o),
        .valid_o          (flu_valid_o),
        .ready_o          (flu_ready_o)
    );

endmodule

//--- testbench/ex_stage_assertions.sv
// Concurrent assertions on the execute stage ports, bound to the top level

`timescale 1ns/1ns

module ex_stage_assertions (
    input logic clk_i,
    input logic rst_ni,
    input logic flush_i,
    input logic alu_valid_i,
    input logic branch_valid_i,
    input logic csr_valid_i,
    input logic mult_valid_i,
    input logic bp_taken_i,
    input logic resolve_branch_i,
    input logic flu_valid_i,
    input logic flu_ready_i
);

    // Read by the testbench summary
    int unsigned fail_count = 0;

    // Resolution needs a branch, or a non-branch issued under a taken prediction
    resolve_has_source: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        resolve_branch_i |-> branch_valid_i
            || (bp_taken_i && (alu_valid_i || csr_valid_i || mult_valid_i))
    ) else begin
        fail_count++;
        $error("resolve_branch_o high without a branch strobe");
    end

    // Multiplier result one cycle after issue unless squashed
    mult_returns: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        mult_valid_i && !flush_i |=> flu_valid_i || flush_i
    ) else begin
        fail_count++;
        $error("flu_valid_o missing one cycle after mult_valid_i");
    end

    ready_in_reset: assert property (
        @(posedge clk_i) !rst_ni |-> flu_ready_i
    ) else begin
        fail_count++;
        $error("flu_ready_o low during reset");
    end

endmodule

//--- testbench/ex_stage_tb.sv
// Testbench for the execute stage with random stimulus and a reference model

`timescale 1ns/1ns

module ex_stage_tb;
    import ex_pkg::*;

    localparam int unsigned Xlen       = XLEN_DEFAULT;
    localparam int unsigned NumRandom  = 40;
    localparam int unsigned ReadyLimit = 20;
    localparam int unsigned UnitAlu    = 0;
    localparam int unsigned UnitBranch = 1;
    localparam int unsigned UnitCsr    = 2;
    localparam int unsigned UnitMult   = 3;

    logic                     clk_i = 1'b0;
    logic                     rst_ni;
    logic                     flush_i;
    fu_op_e                   fu_op_i;
    logic [Xlen-1:0]          operand_a_i;
    logic [Xlen-1:0]          operand_b_i;
    logic [Xlen-1:0]          imm_i;
    logic [Xlen-1:0]          pc_i;
    logic [TRANS_ID_BITS-1:0] trans_id_i;
    logic                     is_compressed_i;
    logic                     alu_valid_i;
    logic                     branch_valid_i;
    logic                     csr_valid_i;
    logic                     mult_valid_i;
    logic                     bp_taken_i;
    logic [Xlen-1:0]          bp_target_i;
    logic                     csr_commit_i;
    logic [Xlen-1:0]          flu_result_o;
    logic [TRANS_ID_BITS-1:0] flu_trans_id_o;
    logic                     flu_valid_o;
    logic                     flu_ready_o;
    logic                     flu_exception_o;
    logic                     resolve_branch_o;
    logic                     resolved_taken_o;
    logic                     resolved_mispredict_o;
    logic [Xlen-1:0]          resolved_target_o;
    logic [CSR_ADDR_BITS-1:0] csr_addr_o;

    int unsigned num_tests   = 0;
    int unsigned num_checks  = 0;
    int unsigned num_errors  = 0;
    int unsigned test_start  = 0;
    int unsigned all_errors;

    always #4 clk_i = ~clk_i;

    ex_stage #(.Xlen(Xlen)) ex_stage_i (.*);

    bind ex_stage ex_stage_assertions assertions_i (
        .clk_i,
        .rst_ni,
        .flush_i,
        .alu_valid_i,
        .branch_valid_i,
        .csr_valid_i,
        .mult_valid_i,
        .bp_taken_i,
        .resolve_branch_i (resolve_branch_o),
        .flu_valid_i      (flu_valid_o),
        .flu_ready_i      (flu_ready_o)
    );

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic logic [Xlen-1:0] alu_model(input fu_op_e op,
                                                  input logic [Xlen-1:0] a,
                                                  input logic [Xlen-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << (b % Xlen);
            OP_SRL:  return a >> (b % Xlen);
            OP_SLT:  return Xlen'($signed(a) < $signed(b));
            OP_SLTU: return Xlen'(a < b);
            default: return '0;
        endcase
    endfunction

    function automatic logic taken_model(input fu_op_e op, input logic [Xlen-1:0] a,
                                         input logic [Xlen-1:0] b);
        case (op)
            OP_BEQ:  return a == b;
            OP_BNE:  return a != b;
            OP_BLT:  return $signed(a) < $signed(b);
            OP_BGEU: return a >= b;
            default: return 1'b1;
        endcase
    endfunction

    // Signed product from sign extended operands
    function automatic logic [Xlen-1:0] mult_model(input fu_op_e op,
                                                   input logic [Xlen-1:0] a,
                                                   input logic [Xlen-1:0] b);
        logic [2*Xlen-1:0] p;
        p = {{Xlen{a[Xlen-1]}}, a} * {{Xlen{b[Xlen-1]}}, b};
        return (op == OP_MULH) ? p[2*Xlen-1:Xlen] : p[Xlen-1:0];
    endfunction

    // ------------------------------------------------------------------------
    // Drivers and checks
    // ------------------------------------------------------------------------
    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        num_checks++;
        if (expected !== actual) begin
            num_errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic finish_test(input string name);
        num_tests++;
        $display("%s: done, %0d errors", name, num_errors - test_start);
        test_start = num_errors;
    endtask

    task automatic set_idle();
        alu_valid_i    <= 1'b0;
        branch_valid_i <= 1'b0;
        csr_valid_i    <= 1'b0;
        mult_valid_i   <= 1'b0;
        flush_i        <= 1'b0;
        csr_commit_i   <= 1'b0;
        bp_taken_i     <= 1'b0;
    endtask

    // Issuer holds strobes low while the stage is not ready
    task automatic wait_ready();
        int unsigned cycles;
        cycles = 0;
        @(negedge clk_i);
        while (!flu_ready_o && cycles < ReadyLimit) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!flu_ready_o) begin
            num_errors++;
            $display("timeout: flu_ready_o stayed low for %0d cycles", ReadyLimit);
        end
    endtask

    task automatic issue(input fu_op_e op, input logic [Xlen-1:0] a,
                         input logic [Xlen-1:0] b, input logic [Xlen-1:0] imm,
                         input logic [TRANS_ID_BITS-1:0] id, input int unsigned unit);
        @(posedge clk_i);
        fu_op_i        <= op;
        operand_a_i    <= a;
        operand_b_i    <= b;
        imm_i          <= imm;
        trans_id_i     <= id;
        alu_valid_i    <= unit == UnitAlu;
        branch_valid_i <= unit == UnitBranch;
        csr_valid_i    <= unit == UnitCsr;
        mult_valid_i   <= unit == UnitMult;
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic alu_ops();
        fu_op_e                   op;
        logic [Xlen-1:0]          a;
        logic [Xlen-1:0]          b;
        logic [TRANS_ID_BITS-1:0] id;
        for (int i = 0; i < NumRandom; i++) begin
            op = fu_op_e'($urandom_range(OP_SLTU, OP_ADD));
            a  = $urandom;
            b  = $urandom_range(1, 0) ? a : $urandom;
            id = $urandom;
            wait_ready();
            issue(op, a, b, $urandom, id, UnitAlu);
            @(negedge clk_i);
            check_value("alu result", alu_model(op, a, b), flu_result_o);
            check_value("alu trans_id", id, flu_trans_id_o);
            check_value("alu valid", 1'b1, flu_valid_o);
            @(posedge clk_i);
            set_idle();
        end
        finish_test("alu");
    endtask

    // Branches under random predictions and non-branches predicted taken
    task automatic branch_resolution(input logic non_branch);
        fu_op_e                   op;
        logic [Xlen-1:0]          a;
        logic [Xlen-1:0]          b;
        logic [Xlen-1:0]          imm;
        logic [Xlen-1:0]          pc;
        logic [Xlen-1:0]          link;
        logic [Xlen-1:0]          tgt;
        logic [TRANS_ID_BITS-1:0] id;
        logic                     comp;
        logic                     taken;
        logic                     pred;
        logic [Xlen-1:0]          pred_tgt;
        for (int i = 0; i < NumRandom; i++) begin
            op   = non_branch ? fu_op_e'($urandom_range(OP_SLTU, OP_ADD))
                              : fu_op_e'($urandom_range(OP_JALR, OP_BEQ));
            a    = $urandom;
            b    = $urandom_range(1, 0) ? a : $urandom;
            imm  = $urandom_range(4095, 0) - 2048;
            pc   = $urandom & ~Xlen'(1);
            id   = $urandom;
            comp = $urandom_range(1, 0);
            link = pc + (comp ? 2 : 4);
            tgt  = (op == OP_JALR) ? ((a + imm) & ~Xlen'(1)) : pc + imm;
            taken = non_branch ? 1'b0 : taken_model(op, a, b);
            pred  = non_branch ? 1'b1 : $urandom_range(1, 0);
            pred_tgt = $urandom_range(1, 0) ? tgt : $urandom;
            wait_ready();
            issue(op, a, b, imm, id, non_branch ? UnitAlu : UnitBranch);
            pc_i            <= pc;
            is_compressed_i <= comp;
            bp_taken_i      <= pred;
            bp_target_i     <= pred_tgt;
            @(negedge clk_i);
            check_value("resolve", 1'b1, resolve_branch_o);
            check_value("taken", taken, resolved_taken_o);
            check_value("target", taken ? tgt : link, resolved_target_o);
            check_value("mispredict", (taken != pred) || (taken && tgt != pred_tgt),
                        resolved_mispredict_o);
            check_value("exception", taken && tgt[0], flu_exception_o);
            check_value("branch result", non_branch ? alu_model(op, a, b) : link,
                        flu_result_o);
            check_value("branch trans_id", id, flu_trans_id_o);
            @(posedge clk_i);
            set_idle();
        end
        finish_test(non_branch ? "predicted non-branch" : "branch");
    endtask

    task automatic csr_blocking();
        logic [Xlen-1:0]          a;
        logic [Xlen-1:0]          imm;
        logic [TRANS_ID_BITS-1:0] id;
        logic                     use_flush;
        for (int i = 0; i < NumRandom / 4; i++) begin
            a   = $urandom;
            imm = $urandom;
            id  = $urandom;
            use_flush = $urandom_range(1, 0);
            wait_ready();
            issue(OP_CSRRW, a, $urandom, imm, id, UnitCsr);
            @(negedge clk_i);
            check_value("csr result", a, flu_result_o);
            check_value("csr trans_id", id, flu_trans_id_o);
            check_value("csr valid", 1'b1, flu_valid_o);
            @(posedge clk_i);
            set_idle();
            repeat ($urandom_range(3, 1)) begin
                @(negedge clk_i);
                check_value("csr ready while full", 1'b0, flu_ready_o);
                check_value("csr address", imm[CSR_ADDR_BITS-1:0], csr_addr_o);
            end
            @(posedge clk_i);
            csr_commit_i <= ~use_flush;
            flush_i      <= use_flush;
            @(negedge clk_i);
            check_value("csr ready at free", 1'b0, flu_ready_o);
            @(posedge clk_i);
            set_idle();
            @(negedge clk_i);
            check_value("csr ready after free", 1'b1, flu_ready_o);
        end
        finish_test("csr");
    endtask

    // Output one cycle after issue unless a flush in either cycle squashes it
    task automatic mult_latency(input logic with_flush);
        fu_op_e                   op;
        logic [Xlen-1:0]          a;
        logic [Xlen-1:0]          b;
        logic [TRANS_ID_BITS-1:0] id;
        logic                     early;
        for (int i = 0; i < NumRandom; i++) begin
            op    = $urandom_range(1, 0) ? OP_MULH : OP_MUL;
            a     = $urandom;
            b     = $urandom;
            id    = $urandom;
            early = $urandom_range(1, 0);
            wait_ready();
            issue(op, a, b, $urandom, id, UnitMult);
            flush_i <= with_flush && early;
            @(posedge clk_i);
            set_idle();
            flush_i <= with_flush && !early;
            @(negedge clk_i);
            check_value("mult valid", !with_flush, flu_valid_o);
            if (!with_flush) begin
                check_value("mult result", mult_model(op, a, b), flu_result_o);
                check_value("mult trans_id", id, flu_trans_id_o);
            end
            @(posedge clk_i);
            set_idle();
            @(negedge clk_i);
            check_value("valid after mult", 1'b0, flu_valid_o);
        end
        finish_test(with_flush ? "mult flush" : "mult");
    endtask

    // ------------------------------------------------------------------------
    // Sequence
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(32'he1e1_d9da));
        fu_op_i         = OP_ADD;
        operand_a_i     = '0;
        operand_b_i     = '0;
        imm_i           = '0;
        pc_i            = '0;
        trans_id_i      = '0;
        is_compressed_i = 1'b0;
        bp_target_i     = '0;
        alu_valid_i     = 1'b0;
        branch_valid_i  = 1'b0;
        csr_valid_i     = 1'b0;
        mult_valid_i    = 1'b0;
        flush_i         = 1'b0;
        csr_commit_i    = 1'b0;
        bp_taken_i      = 1'b0;
        // Falling edge clears the registers before the first clock
        rst_ni = 1'b1;
        #1 rst_ni = 1'b0;
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;

        @(negedge clk_i);
        check_value("reset valid", 1'b0, flu_valid_o);
        check_value("reset resolve", 1'b0, resolve_branch_o);
        check_value("reset ready", 1'b1, flu_ready_o);
        check_value("reset csr address", '0, csr_addr_o);
        finish_test("reset");

        alu_ops();
        branch_resolution(1'b0);
        branch_resolution(1'b1);
        csr_blocking();
        mult_latency(1'b0);
        mult_latency(1'b1);

        all_errors = num_errors + ex_stage_i.assertions_i.fail_count;
        $display("tests %0d, checks %0d, errors %0d", num_tests, num_checks, all_errors);
        if (all_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
design/ex_pkg.sv
design/fu_data_if.sv
design/fu_issue.sv
design/alu.sv
design/branch_unit.sv
design/csr_buffer.sv
design/mult_unit.sv
design/flu_writeback.sv
design/ex_stage.sv
testbench/ex_stage_assertions.sv
testbench/ex_stage_tb.sv
